// File: src/recon_pkg.sv
//----------------------------------------------------------
// Shared widths and fixed-point constants
// Pixel and coefficient block types
// Quantizer register map and reset defaults
//----------------------------------------------------------
package recon_pkg;

    localparam int BLK_PIX  = 16;
    localparam int PIX_W    = 8;
    localparam int COEF_W   = 16;
    localparam int CFG_W    = 32;
    localparam int Q_W      = 16;
    localparam int QP_W     = 20;
    localparam int QFIX     = 17;
    localparam int PIPE_LAT = 3;

    // Raster order, index 0 at top left
    typedef logic [BLK_PIX-1:0][PIX_W-1:0] pix_blk_t;

    // Index 0 holds the DC coefficient
    typedef logic signed [BLK_PIX-1:0][COEF_W-1:0] coef_blk_t;

    //----------------------------------------------------------
    // Quantizer register map
    //----------------------------------------------------------
    typedef enum logic [2:0] {
        Q_DC,
        Q_AC,
        IQ_DC,
        IQ_AC,
        BIAS_DC,
        BIAS_AC,
        ZTHR_DC,
        ZTHR_AC
    } quant_reg_e;

    // Unity quantizer at reset
    localparam logic [Q_W-1:0]  Q_RESET    = 16'd1;
    localparam logic [QP_W-1:0] IQ_RESET   = 20'd131072;
    localparam logic [QP_W-1:0] BIAS_RESET = 20'd0;
    localparam logic [QP_W-1:0] ZTHR_RESET = 20'd0;

endpackage

// File: src/quant_regs.sv
//----------------------------------------------------------
// Quantizer settings register bank
// Separate DC and AC sets, written one word at a time
//----------------------------------------------------------
`timescale 1ns/1ps

module quant_regs import recon_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cfg_we,
    input  quant_reg_e       cfg_addr,
    input  logic [CFG_W-1:0] cfg_wdata,
    output logic [Q_W-1:0]   q_dc,
    output logic [Q_W-1:0]   q_ac,
    output logic [QP_W-1:0]  iq_dc,
    output logic [QP_W-1:0]  iq_ac,
    output logic [QP_W-1:0]  bias_dc,
    output logic [QP_W-1:0]  bias_ac,
    output logic [QP_W-1:0]  zthr_dc,
    output logic [QP_W-1:0]  zthr_ac
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_dc    <= Q_RESET;
            q_ac    <= Q_RESET;
            iq_dc   <= IQ_RESET;
            iq_ac   <= IQ_RESET;
            bias_dc <= BIAS_RESET;
            bias_ac <= BIAS_RESET;
            zthr_dc <= ZTHR_RESET;
            zthr_ac <= ZTHR_RESET;
        end else if (cfg_we) begin
            // Upper data bits are ignored
            case (cfg_addr)
                Q_DC:    q_dc    <= cfg_wdata[Q_W-1:0];
                Q_AC:    q_ac    <= cfg_wdata[Q_W-1:0];
                IQ_DC:   iq_dc   <= cfg_wdata[QP_W-1:0];
                IQ_AC:   iq_ac   <= cfg_wdata[QP_W-1:0];
                BIAS_DC: bias_dc <= cfg_wdata[QP_W-1:0];
                BIAS_AC: bias_ac <= cfg_wdata[QP_W-1:0];
                ZTHR_DC: zthr_dc <= cfg_wdata[QP_W-1:0];
                ZTHR_AC: zthr_ac <= cfg_wdata[QP_W-1:0];
            endcase
        end
    end

endmodule

// File: src/fdct_stage.sv
//----------------------------------------------------------
// Residual and VP8 forward 4x4 transform
// Registers coefficients, prediction and valid
//----------------------------------------------------------
`timescale 1ns/1ps

module fdct_stage import recon_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid,
    input  pix_blk_t  src_blk,
    input  pix_blk_t  pred_blk,
    output logic      s1_valid,
    output coef_blk_t s1_coef,
    output pix_blk_t  s1_pred
);

    int tmp  [BLK_PIX];
    int coef [BLK_PIX];

    // Row pass on the residual
    always_comb begin
        int d0, d1, d2, d3;
        int a0, a1, a2, a3;
        for (int r = 0; r < 4; r++) begin
            d0 = int'(src_blk[4*r+0]) - int'(pred_blk[4*r+0]);
            d1 = int'(src_blk[4*r+1]) - int'(pred_blk[4*r+1]);
            d2 = int'(src_blk[4*r+2]) - int'(pred_blk[4*r+2]);
            d3 = int'(src_blk[4*r+3]) - int'(pred_blk[4*r+3]);
            a0 = d0 + d3;
            a1 = d1 + d2;
            a2 = d1 - d2;
            a3 = d0 - d3;
            tmp[4*r+0] = (a0 + a1) * 8;
            tmp[4*r+2] = (a0 - a1) * 8;
            // Flat row has no odd terms, so no rounding bias either
            if (a2 == 0 && a3 == 0) begin
                tmp[4*r+1] = 0;
                tmp[4*r+3] = 0;
            end else begin
                tmp[4*r+1] = (a2 * 2217 + a3 * 5352 + 1812) >>> 9;
                tmp[4*r+3] = (a3 * 2217 - a2 * 5352 + 937) >>> 9;
            end
        end
    end

    // Column pass
    always_comb begin
        int a0, a1, a2, a3;
        for (int c = 0; c < 4; c++) begin
            a0 = tmp[c] + tmp[12+c];
            a1 = tmp[4+c] + tmp[8+c];
            a2 = tmp[4+c] - tmp[8+c];
            a3 = tmp[c] - tmp[12+c];
            coef[c]    = (a0 + a1 + 7) >>> 4;
            coef[4+c]  = ((a2 * 2217 + a3 * 5352 + 12000) >>> 16) + ((a3 != 0) ? 1 : 0);
            coef[8+c]  = (a0 - a1 + 7) >>> 4;
            coef[12+c] = (a3 * 2217 - a2 * 5352 + 51000) >>> 16;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s1_coef  <= '0;
            s1_pred  <= '0;
        end else begin
            s1_valid <= in_valid;
            if (in_valid) begin
                for (int k = 0; k < BLK_PIX; k++) begin
                    s1_coef[k] <= COEF_W'(coef[k]);
                end
                s1_pred <= pred_blk;
            end
        end
    end

endmodule

// File: src/quant_stage.sv
//----------------------------------------------------------
// Dead-zone quantizer and dequantizer per coefficient
// Nonzero detect, registered with the prediction
//----------------------------------------------------------
`timescale 1ns/1ps

module quant_stage import recon_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            s1_valid,
    input  coef_blk_t       s1_coef,
    input  pix_blk_t        s1_pred,
    input  logic [Q_W-1:0]  q_dc,
    input  logic [Q_W-1:0]  q_ac,
    input  logic [QP_W-1:0] iq_dc,
    input  logic [QP_W-1:0] iq_ac,
    input  logic [QP_W-1:0] bias_dc,
    input  logic [QP_W-1:0] bias_ac,
    input  logic [QP_W-1:0] zthr_dc,
    input  logic [QP_W-1:0] zthr_ac,
    output logic            s2_valid,
    output coef_blk_t       s2_levels,
    output logic            s2_nz,
    output coef_blk_t       s2_dq,
    output pix_blk_t        s2_pred
);

    localparam longint COEF_MAX = 2**(COEF_W-1) - 1;
    localparam longint COEF_MIN = -(2**(COEF_W-1));

    coef_blk_t lev_nx;
    coef_blk_t dq_nx;
    logic      nz_nx;

    function automatic logic [COEF_W-1:0] sat_coef(input longint v);
        if (v > COEF_MAX) begin
            return COEF_W'(COEF_MAX);
        end else if (v < COEF_MIN) begin
            return COEF_W'(COEF_MIN);
        end
        return COEF_W'(v);
    endfunction

    always_comb begin
        longint          c, mag, lev;
        logic [Q_W-1:0]  q;
        logic [QP_W-1:0] iq, bias, zthr;
        nz_nx = 1'b0;
        for (int k = 0; k < BLK_PIX; k++) begin
            // DC set for index 0 only
            q    = (k == 0) ? q_dc    : q_ac;
            iq   = (k == 0) ? iq_dc   : iq_ac;
            bias = (k == 0) ? bias_dc : bias_ac;
            zthr = (k == 0) ? zthr_dc : zthr_ac;
            c   = longint'($signed(s1_coef[k]));
            mag = (c < 0) ? -c : c;
            if (mag > longint'(zthr)) begin
                lev = (mag * longint'(iq) + longint'(bias)) >>> QFIX;
            end else begin
                lev = 0;
            end
            lev       = (c < 0) ? -lev : lev;
            lev_nx[k] = sat_coef(lev);
            dq_nx[k]  = sat_coef(longint'($signed(lev_nx[k])) * longint'(q));
            nz_nx     = nz_nx | (lev_nx[k] != '0);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s2_valid  <= 1'b0;
            s2_levels <= '0;
            s2_nz     <= 1'b0;
            s2_dq     <= '0;
            s2_pred   <= '0;
        end else begin
            s2_valid <= s1_valid;
            if (s1_valid) begin
                s2_levels <= lev_nx;
                s2_nz     <= nz_nx;
                s2_dq     <= dq_nx;
                s2_pred   <= s1_pred;
            end
        end
    end

endmodule

// File: src/idct_recon_stage.sv
//----------------------------------------------------------
// VP8 inverse 4x4 transform
// Prediction add and clamp, registered block outputs
//----------------------------------------------------------
`timescale 1ns/1ps

module idct_recon_stage import recon_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      s2_valid,
    input  coef_blk_t s2_levels,
    input  logic      s2_nz,
    input  coef_blk_t s2_dq,
    input  pix_blk_t  s2_pred,
    output logic      out_valid,
    output coef_blk_t levels,
    output logic      nz,
    output pix_blk_t  recon_blk
);

    int       tmp [BLK_PIX];
    int       res [BLK_PIX];
    pix_blk_t recon_nx;

    // sqrt(2)*cos(pi/8) and sqrt(2)*sin(pi/8) in Q16
    function automatic int mul1(input int a);
        return int'(((longint'(a) * 20091) >>> 16) + longint'(a));
    endfunction

    function automatic int mul2(input int a);
        return int'((longint'(a) * 35468) >>> 16);
    endfunction

    // Vertical pass
    always_comb begin
        int a, b, c, d;
        int x [BLK_PIX];
        for (int k = 0; k < BLK_PIX; k++) begin
            x[k] = int'($signed(s2_dq[k]));
        end
        for (int i = 0; i < 4; i++) begin
            a = x[i] + x[8+i];
            b = x[i] - x[8+i];
            c = mul2(x[4+i]) - mul1(x[12+i]);
            d = mul1(x[4+i]) + mul2(x[12+i]);
            tmp[4*i+0] = a + d;
            tmp[4*i+1] = b + c;
            tmp[4*i+2] = b - c;
            tmp[4*i+3] = a - d;
        end
    end

    // Horizontal pass with final rounding
    always_comb begin
        int dc, a, b, c, d;
        for (int i = 0; i < 4; i++) begin
            dc = tmp[i] + 4;
            a  = dc + tmp[8+i];
            b  = dc - tmp[8+i];
            c  = mul2(tmp[4+i]) - mul1(tmp[12+i]);
            d  = mul1(tmp[4+i]) + mul2(tmp[12+i]);
            res[4*i+0] = (a + d) >>> 3;
            res[4*i+1] = (b + c) >>> 3;
            res[4*i+2] = (b - c) >>> 3;
            res[4*i+3] = (a - d) >>> 3;
        end
    end

    always_comb begin
        int p;
        for (int k = 0; k < BLK_PIX; k++) begin
            p = int'(s2_pred[k]) + res[k];
            if (p < 0) begin
                recon_nx[k] = '0;
            end else if (p > 2**PIX_W - 1) begin
                recon_nx[k] = '1;
            end else begin
                recon_nx[k] = PIX_W'(p);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            levels    <= '0;
            nz        <= 1'b0;
            recon_blk <= '0;
        end else begin
            out_valid <= s2_valid;
            if (s2_valid) begin
                levels    <= s2_levels;
                nz        <= s2_nz;
                recon_blk <= recon_nx;
            end
        end
    end

endmodule

// File: src/recon_top.sv
//----------------------------------------------------------
// Luma sub-block reconstruction top level
// Register bank plus three-stage pipeline
//----------------------------------------------------------
`timescale 1ns/1ps

module recon_top import recon_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cfg_we,
    input  quant_reg_e       cfg_addr,
    input  logic [CFG_W-1:0] cfg_wdata,
    input  logic             in_valid,
    input  pix_blk_t         src_blk,
    input  pix_blk_t         pred_blk,
    output logic             out_valid,
    output coef_blk_t        levels,
    output logic             nz,
    output pix_blk_t         recon_blk
);

    logic [Q_W-1:0]  q_dc, q_ac;
    logic [QP_W-1:0] iq_dc, iq_ac, bias_dc, bias_ac, zthr_dc, zthr_ac;

    logic      s1_valid, s2_valid, s2_nz;
    coef_blk_t s1_coef, s2_levels, s2_dq;
    pix_blk_t  s1_pred, s2_pred;

    quant_regs u_quant_regs (
        .clk(clk), .rst_n(rst_n),
        .cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
        .q_dc(q_dc), .q_ac(q_ac), .iq_dc(iq_dc), .iq_ac(iq_ac),
        .bias_dc(bias_dc), .bias_ac(bias_ac), .zthr_dc(zthr_dc), .zthr_ac(zthr_ac)
    );

    //----------------------------------------------------------
    // Pipeline, one register per stage
    //----------------------------------------------------------
    fdct_stage u_fdct (
        .clk(clk), .rst_n(rst_n),
        .in_valid(in_valid), .src_blk(src_blk), .pred_blk(pred_blk),
        .s1_valid(s1_valid), .s1_coef(s1_coef), .s1_pred(s1_pred)
    );

    quant_stage u_quant (
        .clk(clk), .rst_n(rst_n),
        .s1_valid(s1_valid), .s1_coef(s1_coef), .s1_pred(s1_pred),
        .q_dc(q_dc), .q_ac(q_ac), .iq_dc(iq_dc), .iq_ac(iq_ac),
        .bias_dc(bias_dc), .bias_ac(bias_ac), .zthr_dc(zthr_dc), .zthr_ac(zthr_ac),
        .s2_valid(s2_valid), .s2_levels(s2_levels), .s2_nz(s2_nz),
        .s2_dq(s2_dq), .s2_pred(s2_pred)
    );

    idct_recon_stage u_idct (
        .clk(clk), .rst_n(rst_n),
        .s2_valid(s2_valid), .s2_levels(s2_levels), .s2_nz(s2_nz),
        .s2_dq(s2_dq), .s2_pred(s2_pred),
        .out_valid(out_valid), .levels(levels), .nz(nz), .recon_blk(recon_blk)
    );

endmodule

// File: sim/recon_asserts.sv
//----------------------------------------------------------
// Concurrent checks on pipeline valid timing and nz
// Bound into recon_top
//----------------------------------------------------------
`timescale 1ns/1ps

module recon_asserts (
    input logic clk,
    input logic rst_n,
    input logic in_valid,
    input logic out_valid,
    input logic nz
);

    // Read by the testbench monitor
    int err_cnt = 0;

    // Three register stages from input strobe to output strobe
    valid_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid == $past(in_valid, 3)
    ) else begin
        $error("out_valid does not follow in_valid by three cycles");
        err_cnt++;
    end

    // nz only updates together with a new output block
    nz_with_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        $changed(nz) |-> out_valid
    ) else begin
        $error("nz changed while out_valid was low");
        err_cnt++;
    end

    valid_in_reset: assert property (
        @(posedge clk) !rst_n |-> !out_valid
    ) else begin
        $error("out_valid high during reset");
        err_cnt++;
    end

endmodule

bind recon_top recon_asserts u_asserts (
    .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .out_valid(out_valid), .nz(nz)
);

// File: sim/tb_recon.sv
//----------------------------------------------------------
// Testbench for the luma sub-block reconstruction pipeline
// Flat-residual stimulus, reference model, expected queues
//----------------------------------------------------------
`timescale 1ns/1ps

module tb_recon import recon_pkg::*; ();

    logic             clk;
    logic             rst_n;
    logic             cfg_we;
    quant_reg_e       cfg_addr;
    logic [CFG_W-1:0] cfg_wdata;
    logic             in_valid;
    pix_blk_t         src_blk;
    pix_blk_t         pred_blk;
    logic             out_valid;
    coef_blk_t        levels;
    logic             nz;
    pix_blk_t         recon_blk;

    // Model copy of the DC quantizer set
    int m_q    = int'(Q_RESET);
    int m_iq   = int'(IQ_RESET);
    int m_bias = int'(BIAS_RESET);
    int m_zthr = int'(ZTHR_RESET);

    string     name_q  [$];
    coef_blk_t lev_q   [$];
    logic      nz_q    [$];
    pix_blk_t  recon_q [$];

    logic [31:0] rng_state = 32'd54713;

    recon_top u_recon_top (
        .clk(clk), .rst_n(rst_n),
        .cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
        .in_valid(in_valid), .src_blk(src_blk), .pred_blk(pred_blk),
        .out_valid(out_valid), .levels(levels), .nz(nz), .recon_blk(recon_blk)
    );

    always #20 clk = ~clk;

    //----------------------------------------------------------
    // Helpers
    //----------------------------------------------------------
    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic pix_blk_t rand_pred(input int lo, input int hi);
        pix_blk_t b;
        for (int k = 0; k < BLK_PIX; k++) begin
            b[k] = PIX_W'(lo + int'(next_rand() % (hi - lo + 1)));
        end
        return b;
    endfunction

    // Dead zone, then scaled magnitude with the sign put back
    function automatic int quant_level(input int c);
        int mag;
        int lev;
        mag = (c < 0) ? -c : c;
        if (mag <= m_zthr) begin
            return 0;
        end
        lev = int'((longint'(mag) * longint'(m_iq) + longint'(m_bias)) >>> QFIX);
        return (c < 0) ? -lev : lev;
    endfunction

    task automatic fail_run();
        $display("Simulation failed");
        $fatal(1, "Stopping at first error");
    endtask

    task automatic check_val(input string name, input logic [255:0] exp,
                             input logic [255:0] act);
        assert (exp == act) else begin
            $display("[ERROR] %s: expected %0h, actual %0h", name, exp, act);
            fail_run();
        end
    endtask

    task automatic write_cfg(input quant_reg_e addr, input int val);
        @(posedge clk);
        cfg_we    <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= CFG_W'(val);
        @(posedge clk);
        cfg_we    <= 1'b0;
        case (addr)
            Q_DC:    m_q    = val;
            IQ_DC:   m_iq   = val;
            BIAS_DC: m_bias = val;
            ZTHR_DC: m_zthr = val;
            default: ;
        endcase
    endtask

    // Flat residual d: only DC is 8*d, so only level 0 can be nonzero
    task automatic send_block(input string name, input pix_blk_t pred, input int d);
        pix_blk_t  src;
        pix_blk_t  exp_recon;
        coef_blk_t exp_lev;
        int        lev;
        int        dq;
        int        p;
        lev        = quant_level(8 * d);
        dq         = lev * m_q;
        exp_lev    = '0;
        exp_lev[0] = COEF_W'(lev);
        for (int k = 0; k < BLK_PIX; k++) begin
            src[k] = PIX_W'(int'(pred[k]) + d);
            p = int'(pred[k]) + ((dq + 4) >>> 3);
            exp_recon[k] = (p < 0) ? 8'd0 : ((p > 255) ? 8'd255 : PIX_W'(p));
        end
        name_q.push_back(name);
        lev_q.push_back(exp_lev);
        nz_q.push_back(lev != 0);
        recon_q.push_back(exp_recon);
        @(posedge clk);
        in_valid <= 1'b1;
        src_blk  <= src;
        pred_blk <= pred;
    endtask

    task automatic end_burst();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (name_q.size() != 0) begin
            if (n == 20) begin
                $display("Timeout: out_valid never arrived for block %s", name_q[0]);
                fail_run();
            end
            @(posedge clk);
            n++;
        end
    endtask

    task automatic run_block(input string name, input pix_blk_t pred, input int d);
        send_block(name, pred, d);
        end_burst();
        wait_drain();
    endtask

    //----------------------------------------------------------
    // Output checking
    //----------------------------------------------------------
    always @(negedge clk) begin : check_out
        string cur;
        if (rst_n && out_valid) begin
            if (name_q.size() == 0) begin
                $display("out_valid was high with no block outstanding");
                fail_run();
            end else begin
                cur = name_q.pop_front();
                check_val({cur, " levels"}, lev_q.pop_front(), levels);
                check_val({cur, " nz"}, nz_q.pop_front(), nz);
                check_val({cur, " recon_blk"}, recon_q.pop_front(), recon_blk);
            end
        end
    end

    always @(negedge clk) begin
        if (u_recon_top.u_asserts.err_cnt != 0) begin
            $display("A bound assertion on valid timing or nz failed");
            fail_run();
        end
    end

    //----------------------------------------------------------
    // Stimulus
    //----------------------------------------------------------
    initial begin
        int d;
        clk       = 1'b0;
        rst_n     = 1'b0;
        cfg_we    = 1'b0;
        cfg_addr  = Q_DC;
        cfg_wdata = '0;
        in_valid  = 1'b0;
        src_blk   = '0;
        pred_blk  = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_val("reset out_valid", 256'd0, out_valid);
        check_val("reset nz", 256'd0, nz);

        run_block("zero_residual", rand_pred(0, 255), 0);
        run_block("flat_reset_pos", rand_pred(30, 200), 9);
        run_block("flat_reset_neg", rand_pred(30, 200), -13);

        // DC of 48 falls inside the dead zone
        write_cfg(ZTHR_DC, 50);
        run_block("dead_zone", rand_pred(20, 235), 6);
        write_cfg(ZTHR_DC, 10);
        write_cfg(IQ_DC, 65536);
        write_cfg(BIAS_DC, 65536);
        write_cfg(Q_DC, 3);
        run_block("programmed_pos", rand_pred(20, 235), 6);
        run_block("programmed_neg", rand_pred(20, 235), -7);

        // Gain above one pushes the sum past the pixel range
        run_block("clamp_high", rand_pred(246, 249), 6);
        run_block("clamp_low", rand_pred(7, 9), -7);

        for (int i = 0; i < 20; i++) begin
            d = int'(next_rand() % 32'd41) - 20;
            send_block("random_b2b", rand_pred(20, 235), d);
        end
        end_burst();
        wait_drain();

        repeat (2) @(posedge clk);
        if (u_recon_top.u_asserts.err_cnt == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("A bound assertion failed near the end of the run");
            fail_run();
        end
    end

endmodule

// File: src.f
src/recon_pkg.sv
src/quant_regs.sv
src/fdct_stage.sv
src/quant_stage.sv
src/idct_recon_stage.sv
src/recon_top.sv
sim/recon_asserts.sv
sim/tb_recon.sv

// File: Bender.yml
package:
  name: vp8_recon

sources:
  - src/recon_pkg.sv
  - src/quant_regs.sv
  - src/fdct_stage.sv
  - src/quant_stage.sv
  - src/idct_recon_stage.sv
  - src/recon_top.sv
  - target: simulation
    files:
      - sim/recon_asserts.sv
      - sim/tb_recon.sv
